// File: cp0_lite.sv
`timescale 1ns/100ps
`default_nettype none

module cp0_lite
    import mips_isa_pkg::*, pipe_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  wb_event_t   wb_event,
    output redirect_t   redirect,
    output logic [31:0] cp0_epc,
    output logic        cp0_exl
);

    logic [31:0] epc;                     // return address for eret
    logic        exl;                     // exception level
    logic        take_exc;

    assign take_exc = wb_event.valid & ~wb_event.is_eret;

    always_ff @(posedge clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (wb_event.valid) begin
            exl <= ~wb_event.is_eret;     // set on exception, cleared by eret
        end
    end

    always_ff @(posedge clk) begin
        if (take_exc) begin
            // slot instr restarts at its branch
            epc <= wb_event.bd ? (wb_event.pc - 32'd4) : wb_event.pc;
        end
    end

    // redirect in the event cycle itself
    always_comb begin
        redirect.valid  = wb_event.valid;
        redirect.target = wb_event.is_eret ? epc : EXC_VECTOR;
    end

    assign cp0_epc = epc;
    assign cp0_exl = exl;

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import mips_isa_pkg::*, pipe_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        fs_to_ds_valid,
    input  fs_to_ds_t   fs_to_ds,
    output logic        ds_allowin,
    output br_bus_t     br_bus,
    output logic [4:0]  rs_addr,
    output logic [4:0]  rt_addr,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    input  logic        flush,
    input  logic        es_allowin,
    output logic        ds_to_es_valid,
    output ds_to_es_t   ds_to_es
);

    logic        ds_valid;
    fs_to_ds_t   ds_item;                 // held fetch item
    inst_t       ds_inst;
    logic        ds_leaving;              // item handed downstream this cycle

    logic        is_beq;
    logic        is_bne;
    logic        is_j;
    logic        is_jal;
    logic        is_jr;
    logic        is_branch;
    logic        rs_eq_rt;
    logic        br_cond;                 // branch would be taken
    logic [31:0] ds_pc_plus4;
    logic [31:0] br_offset;
    logic [31:0] br_target;

    // decode never stalls on its own
    assign ds_allowin = ~ds_valid | es_allowin;
    assign ds_leaving = ds_valid & es_allowin & ~flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;             // younger than the excepting instr
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid & ds_allowin) begin
            ds_item <= fs_to_ds;
        end
    end

    assign ds_inst = ds_item.inst;

    // a fetch-excepted item is never a branch
    assign is_beq = ~ds_item.ex & (ds_inst.i.op == OP_BEQ);
    assign is_bne = ~ds_item.ex & (ds_inst.i.op == OP_BNE);
    assign is_j   = ~ds_item.ex & (ds_inst.j.op == OP_J);
    assign is_jal = ~ds_item.ex & (ds_inst.j.op == OP_JAL);
    assign is_jr  = ~ds_item.ex & (ds_inst.r.op == OP_SPECIAL) & (ds_inst.r.funct == FN_JR);

    assign is_branch = is_beq | is_bne | is_j | is_jal | is_jr;

    assign rs_addr = ds_inst.r.rs;
    assign rt_addr = ds_inst.r.rt;

    assign rs_eq_rt = (rs_data == rt_data);
    assign br_cond  = (is_beq & rs_eq_rt) | (is_bne & ~rs_eq_rt) | is_j | is_jal | is_jr;

    assign ds_pc_plus4 = ds_item.pc + 32'd4;
    assign br_offset   = {{14{ds_inst.i.imm16[15]}}, ds_inst.i.imm16, 2'b00};  // words to bytes

    always_comb begin
        if (is_jr) begin
            br_target = rs_data;
        end else if (is_j | is_jal) begin
            br_target = {ds_pc_plus4[31:28], ds_inst.j.index26, 2'b00};  // same 256MB region
        end else begin
            br_target = ds_pc_plus4 + br_offset;  // beq/bne offset from the slot pc
        end
    end

    always_comb begin
        br_bus.taken     = ds_leaving & br_cond;  // only as the branch moves on
        br_bus.target    = br_target;
        br_bus.in_branch = ds_valid & is_branch;
    end

    assign ds_to_es_valid = ds_valid & ~flush;

    always_comb begin
        ds_to_es.ex        = ds_item.ex;
        ds_to_es.exccode   = ds_item.exccode;
        ds_to_es.bd        = ds_item.bd;
        ds_to_es.inst      = ds_item.inst;
        ds_to_es.pc        = ds_item.pc;
        ds_to_es.is_branch = is_branch;
        ds_to_es.br_taken  = br_cond;
    end

endmodule

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage
    import mips_isa_pkg::*, pipe_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ds_allowin,
    input  br_bus_t     br_bus,
    input  redirect_t   redirect,
    output logic        fs_to_ds_valid,
    output fs_to_ds_t   fs_to_ds,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata
);

    logic        fs_allowin;              // pc may move this cycle
    logic [31:0] fs_pc;                   // pc of word now on rdata
    logic [31:0] seq_pc;
    logic [31:0] next_pc;
    logic        adel;                    // misaligned fetch

    assign seq_pc = fs_pc + 32'd4;

    // redirect > branch > sequential
    always_comb begin
        if (redirect.valid) begin
            next_pc = redirect.target;
        end else if (br_bus.taken) begin
            next_pc = br_bus.target;      // delay slot already in fetch
        end else begin
            next_pc = seq_pc;
        end
    end

    assign fs_allowin = redirect.valid | ds_allowin;  // redirect drops the current item

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_to_ds_valid <= 1'b0;
            fs_pc          <= RESET_VECTOR - 32'd4;  // first next_pc lands on reset vector
        end else begin
            fs_to_ds_valid <= 1'b1;                  // always holds a word after reset
            if (fs_allowin) begin
                fs_pc <= next_pc;
            end
        end
    end

    // sram returns next_pc's word one cycle later, together with fs_pc
    assign inst_sram_addr = next_pc;
    assign inst_sram_en   = redirect.valid | (fs_allowin & (next_pc[1:0] == 2'b00));

    assign adel = (fs_pc[1:0] != 2'b00);

    always_comb begin
        fs_to_ds.ex      = adel;
        fs_to_ds.exccode = adel ? EXC_ADEL : EXC_NONE;
        fs_to_ds.bd      = br_bus.in_branch;             // decode holds its branch
        fs_to_ds.inst    = adel ? 32'h0 : inst_sram_rdata;  // no word fetched
        fs_to_ds.pc      = fs_pc;
    end

endmodule

`default_nettype wire

// File: filelist.f
mips_isa_pkg.sv
pipe_bus_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
cp0_lite.sv
frontend_top.sv
tb_frontend.sv

// File: frontend_top.sv
`timescale 1ns/100ps
`default_nettype none

module frontend_top
    import pipe_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        es_allowin,
    output logic        ds_to_es_valid,
    output ds_to_es_t   ds_to_es,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    input  rf_write_t   rf_write,
    input  wb_event_t   wb_event,
    output logic [31:0] cp0_epc,
    output logic        cp0_exl
);

    logic        fs_to_ds_valid;
    fs_to_ds_t   fs_to_ds;
    logic        ds_allowin;
    br_bus_t     br_bus;                  // decode to fetch, same cycle
    redirect_t   redirect;                // cp0 to fetch, also flushes decode
    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;

    fetch_stage fetch0 (
        .clk             (clk),
        .reset           (reset),
        .ds_allowin      (ds_allowin),
        .br_bus          (br_bus),
        .redirect        (redirect),
        .fs_to_ds_valid  (fs_to_ds_valid),
        .fs_to_ds        (fs_to_ds),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata)
    );

    decode_stage decode0 (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .rs_addr        (rs_addr),
        .rt_addr        (rt_addr),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .flush          (redirect.valid),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es)
    );

    reg_file rf0 (
        .clk      (clk),
        .rf_write (rf_write),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rs_data  (rs_data),
        .rt_data  (rt_data)
    );

    cp0_lite cp0 (
        .clk      (clk),
        .reset    (reset),
        .wb_event (wb_event),
        .redirect (redirect),
        .cp0_epc  (cp0_epc),
        .cp0_exl  (cp0_exl)
    );

endmodule

`default_nettype wire

// File: mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // r-type layout
    typedef struct packed {
        logic [5:0] op;                   // primary opcode
        logic [4:0] rs;                   // source reg
        logic [4:0] rt;                   // second source reg
        logic [4:0] rd;                   // dest reg
        logic [4:0] shamt;                // shift amount
        logic [5:0] funct;                // special function
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;               // signed offset or immediate
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index26;             // word index inside 256MB region
    } j_fmt_t;

    // one fetched word, three ways of reading it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } inst_t;

    localparam logic [5:0] OP_SPECIAL = 6'h00;    // funct selects the op
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] FN_JR      = 6'h08;    // under OP_SPECIAL

    localparam logic [4:0] EXC_ADEL   = 5'h04;    // address error on load/fetch
    localparam logic [4:0] EXC_NONE   = 5'h1f;    // no exception pending

    localparam logic [31:0] RESET_VECTOR = 32'hbfc0_0000;  // kseg1 boot rom
    localparam logic [31:0] EXC_VECTOR   = 32'hbfc0_0380;  // general exception, bev=1

endpackage

`default_nettype wire

// File: pipe_bus_pkg.sv
`default_nettype none

package pipe_bus_pkg;

    // decode back to fetch, combinational
    typedef struct packed {
        logic        taken;               // only high while decode item advances
        logic [31:0] target;              // branch or jump destination
        logic        in_branch;           // fetch item is a delay slot
    } br_bus_t;

    typedef struct packed {
        logic        ex;                  // fetch raised an exception
        logic [4:0]  exccode;
        logic        bd;                  // sits in a delay slot
        logic [31:0] inst;                // zero when ex set
        logic [31:0] pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic        ex;
        logic [4:0]  exccode;
        logic        bd;
        logic [31:0] inst;
        logic [31:0] pc;
        logic        is_branch;           // beq/bne/j/jal/jr
        logic        br_taken;            // resolved direction
    } ds_to_es_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } rf_write_t;

    // exception or eret reported at write-back
    typedef struct packed {
        logic        valid;
        logic        is_eret;             // eret wins over exception
        logic        bd;
        logic [4:0]  exccode;
        logic [31:0] pc;
    } wb_event_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file
    import pipe_bus_pkg::*;
(
    input  logic        clk,
    input  rf_write_t   rf_write,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [32];               // r0 entry never written

    always_ff @(posedge clk) begin
        if (rf_write.we && (rf_write.addr != 5'd0)) begin
            regs[rf_write.addr] <= rf_write.data;
        end
    end

    // zero, then bypass of same-cycle write, then array
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'h0;
        end else if (rf_write.we && (rf_write.addr == addr)) begin
            return rf_write.data;
        end
        return regs[addr];
    endfunction

    // reads follow the array and the write port too
    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the frontend testbench with verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/100ps --top-module tb_frontend \
        -f filelist.f -o vsim_frontend; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/vsim_frontend 2>&1)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1

// File: tb_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module tb_frontend
    import mips_isa_pkg::*, pipe_bus_pkg::*;
();

    localparam logic [31:0] SEED    = 32'd70975;
    localparam int          N_ITEMS = 3000;          // accepted output items
    localparam int          TIMEOUT = 200;           // cycles without an accepted item

    logic        clk = 1'b0;
    logic        reset;
    logic        es_allowin;
    logic        ds_to_es_valid;
    ds_to_es_t   ds_to_es;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    rf_write_t   rf_write;
    wb_event_t   wb_event;
    logic [31:0] cp0_epc;
    logic        cp0_exl;

    logic [31:0] rng_state = SEED;
    logic [31:0] prog_mem [logic [31:0]];            // sparse map filled on first touch
    logic [31:0] m_regs [32];                        // architectural copy of the gprs
    logic [31:0] pc_a;                               // pc of next expected item
    logic [31:0] pc_b;                               // following pc where a branch target lands
    logic        m_bd;
    logic [31:0] m_epc;
    logic        m_exl;
    logic        epc_known;                          // epc has no reset value
    wb_event_t   pend;                               // event raised next cycle
    int          handler_cnt;

    frontend_top dut0 (
        .clk             (clk),
        .reset           (reset),
        .es_allowin      (es_allowin),
        .ds_to_es_valid  (ds_to_es_valid),
        .ds_to_es        (ds_to_es),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .rf_write        (rf_write),
        .wb_event        (wb_event),
        .cp0_epc         (cp0_epc),
        .cp0_exl         (cp0_exl)
    );

    always #2 clk = ~clk;                            // 4 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // program word hashed from the whole address, mostly filler
    function automatic logic [31:0] make_word(input logic [31:0] addr);
        logic [31:0] h;
        logic [29:0] tgt_word;
        logic [4:0]  rs;
        logic [4:0]  rt;
        h = xorshift32(xorshift32(addr ^ SEED));
        rs = {3'b000, h[9:8]} + 5'd1;                // r1..r4 hold 0 or 1
        rt = {3'b000, h[11:10]} + 5'd1;
        tgt_word = addr[31:2] + 30'd1 + {{24{h[17]}}, h[17:12]};
        case (h[3:0])
            4'd0:    return {OP_BEQ, rs, rt, {11{h[16]}}, h[16:12]};
            4'd1:    return {OP_BNE, rs, rt, {11{h[16]}}, h[16:12]};
            4'd2:    return {(h[4] ? OP_JAL : OP_J), tgt_word[25:0]};
            4'd3:    return {OP_SPECIAL, 5'd8 + {2'b00, h[6:4]}, 15'd0, FN_JR};  // r15 misaligned
            default: return {OP_SPECIAL, h[20:16], h[25:21], h[30:26], 5'd0, 6'h21};  // addu
        endcase
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (!prog_mem.exists(addr))
            prog_mem[addr] = make_word(addr);
        return prog_mem[addr];
    endfunction

    // architectural view of one item with delay slots
    task automatic predict(input logic [31:0] pc, input logic bd,
                           output ds_to_es_t item, output logic [31:0] target);
        inst_t       w;
        logic [31:0] slot_pc;
        logic        rs_eq;
        slot_pc = pc + 32'd4;
        target  = slot_pc;
        item    = '0;
        item.pc = pc;
        item.bd = bd;
        item.exccode = EXC_NONE;
        if (pc[1:0] != 2'b00) begin
            item.ex      = 1'b1;                     // no word fetched so never a branch
            item.exccode = EXC_ADEL;
        end else begin
            w = word_at(pc);
            item.inst = w;
            rs_eq = (m_regs[w.i.rs] == m_regs[w.i.rt]);
            case (w.r.op)
                OP_BEQ, OP_BNE: begin
                    item.is_branch = 1'b1;
                    item.br_taken  = (w.i.op == OP_BEQ) ? rs_eq : !rs_eq;
                    target = slot_pc + (32'($signed(w.i.imm16)) << 2);
                end
                OP_J, OP_JAL: begin
                    item.is_branch = 1'b1;
                    item.br_taken  = 1'b1;
                    target = (slot_pc & 32'hf000_0000) | {4'h0, w.j.index26, 2'b00};
                end
                OP_SPECIAL: begin
                    if (w.r.funct == FN_JR) begin
                        item.is_branch = 1'b1;
                        item.br_taken  = 1'b1;
                        target = m_regs[w.r.rs];
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic redirect_model(input logic [31:0] target);
        pc_a = target;
        pc_b = target + 32'd4;
        m_bd = 1'b0;                                 // decode is empty after a redirect
    endtask

    task automatic apply_event(input wb_event_t ev);
        if (ev.is_eret) begin
            m_exl = 1'b0;
            redirect_model(m_epc);
        end else begin
            m_epc = ev.bd ? ev.pc - 32'd4 : ev.pc;   // slot restarts at its branch
            m_exl = 1'b1;
            epc_known = 1'b1;
            handler_cnt = 0;
            redirect_model(EXC_VECTOR);
        end
    endtask

    // pick the event that follows an accepted item
    task automatic choose_event(input ds_to_es_t item);
        logic [31:0] r;
        r = next_rand();
        if (m_exl)
            handler_cnt++;
        if (item.ex || ((!m_exl || m_epc[1:0] != 2'b00) && r[5:0] == 6'd0)) begin
            pend.valid   = 1'b1;
            pend.is_eret = 1'b0;
            pend.bd      = item.bd;
            pend.exccode = item.ex ? item.exccode : 5'h08;
            pend.pc      = item.pc;
        end else if (m_exl && handler_cnt >= 6 && m_epc[1:0] == 2'b00) begin
            pend.valid   = 1'b1;
            pend.is_eret = 1'b1;                     // back to epc
        end
    endtask

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failed check");
    endtask

    task automatic check_item(input ds_to_es_t got, input ds_to_es_t exp);
        if (got !== exp) begin
            $display("Error at %0t: output item differs from reference model", $time);
            $display("  got pc %h inst %h bd %b ex %b code %h br %b taken %b", got.pc,
                     got.inst, got.bd, got.ex, got.exccode, got.is_branch, got.br_taken);
            $display("  exp pc %h inst %h bd %b ex %b code %h br %b taken %b", exp.pc,
                     exp.inst, exp.bd, exp.ex, exp.exccode, exp.is_branch, exp.br_taken);
            stop_run();
        end
    endtask

    task automatic check_cp0(input logic [31:0] got_epc, input logic got_exl,
                             input logic [31:0] exp_epc, input logic exp_exl);
        if (got_epc !== exp_epc || got_exl !== exp_exl) begin
            $display("Error at %0t: cp0 epc %h exl %b, expected epc %h exl %b",
                     $time, got_epc, got_exl, exp_epc, exp_exl);
            stop_run();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // instruction sram with one-cycle read latency
    initial begin
        logic        req_en;
        logic [31:0] req_addr;
        inst_sram_rdata = '0;
        forever begin
            @(negedge clk);
            req_en   = inst_sram_en;                 // settled since the input drive
            req_addr = inst_sram_addr;
            if (req_addr[1:0] != 2'b00)
                check_flag("inst_sram_en for a misaligned address", req_en, 1'b0);
            @(posedge clk);
            #1;
            if (req_en)
                inst_sram_rdata = word_at(req_addr);
        end
    end

    initial begin
        ds_to_es_t   exp;
        logic [31:0] tgt;
        logic [31:0] r;
        int          consumed;
        int          idle;
        reset = 1'b1;
        es_allowin = 1'b0;
        rf_write = '0;
        wb_event = '0;
        pend = '0;
        m_exl = 1'b0;
        epc_known = 1'b0;
        handler_cnt = 0;
        consumed = 0;
        idle = 0;
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;
        redirect_model(RESET_VECTOR);

        // r1..r4 for compares, r8..r14 jr targets, r15 misaligned
        for (int i = 0; i < 12; i++) begin
            @(posedge clk);
            #1;
            if (i == 9)
                reset = 1'b0;                        // after 10 cycles
            r = next_rand();
            rf_write.we   = 1'b1;
            rf_write.addr = (i < 4) ? 5'(i + 1) : 5'(i + 4);
            if (i < 4)
                rf_write.data = {31'd0, r[0]};
            else
                rf_write.data = RESET_VECTOR + (r & 32'h0000_fffc) + ((i == 11) ? 32'd2 : 32'd0);
            m_regs[rf_write.addr] = rf_write.data;
            #1;
            if (i <= 10)
                check_flag("ds_to_es_valid after reset", ds_to_es_valid, 1'b0);
            check_flag("cp0_exl after reset", cp0_exl, 1'b0);
        end

        while (consumed < N_ITEMS) begin
            @(posedge clk);
            if (wb_event.valid)
                apply_event(wb_event);               // cp0 and fetch took it at this edge
            #1;
            rf_write   = '0;
            wb_event   = pend;
            pend       = '0;
            r          = next_rand();
            es_allowin = (r[1:0] != 2'b00);          // stall about one cycle in four
            #1;
            if (wb_event.valid)
                check_flag("ds_to_es_valid during redirect", ds_to_es_valid, 1'b0);
            if (epc_known)
                check_cp0(cp0_epc, cp0_exl, m_epc, m_exl);
            else
                check_flag("cp0_exl before any exception", cp0_exl, m_exl);
            if (ds_to_es_valid && es_allowin) begin
                predict(pc_a, m_bd, exp, tgt);
                check_item(ds_to_es, exp);
                pc_a = pc_b;
                pc_b = exp.br_taken ? tgt : pc_a + 32'd4;
                m_bd = exp.is_branch;                // next item sits in its slot
                choose_event(exp);
                consumed++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    $display("timeout: no output item accepted for %0d cycles", TIMEOUT);
                    stop_run();
                end
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
